// File: Bender.yml
package:
  name: mipsCpu

sources:
  # Package first, then the stages and the top level
  - verilog/mipsPkg.sv
  - verilog/fetchUnit.sv
  - verilog/regFile.sv
  - verilog/decodeUnit.sv
  - verilog/execUnit.sv
  - verilog/memWbUnit.sv
  - verilog/mipsCpu.sv

  # Testbench
  - target: simulation
    files:
      - dv/tbMipsCpu.sv

// File: dv/cpuTests.txt
// kind a b c: 1 instr (addr word 0), 2 data (addr word 0), 0 end
// 3 write (pc reg value), 4 store (addr value 0); events in program order
1 00003000 3c011234 00000000
1 00003004 34218765 00000000
1 00003008 3402ffff 00000000
1 0000300c 00221821 00000000
1 00003010 00612023 00000000
1 00003014 00220021 00000000
1 00003018 00042821 00000000
1 0000301c 00023023 00000000
1 00003020 34070010 00000000
1 00003024 ace30004 00000000
1 00003028 ace6fff8 00000000
1 0000302c 8ce80004 00000000
1 00003030 01084821 00000000
1 00003034 8ceafff8 00000000
1 00003038 acea0000 00000000
1 0000303c 8c0b0020 00000000
1 00003040 8c0c0010 00000000
1 00003044 114c0002 00000000
1 00003048 340d0001 00000000
1 0000304c 340d00bb 00000000
1 00003050 01a97021 00000000
1 00003054 11cd0003 00000000
1 00003058 340f0002 00000000
1 0000305c 34100003 00000000
1 00003060 0c000c20 00000000
1 00003064 020f8821 00000000
1 00003068 34120004 00000000
1 0000306c 1000ffff 00000000
1 00003070 00000000 00000000
1 00003080 37f30000 00000000
1 00003084 03e00008 00000000
1 00003088 0271a021 00000000
1 0000308c 341500ee 00000000
2 00000020 cafef00d 00000000
3 00003000 00000001 12340000
3 00003004 00000001 12348765
3 00003008 00000002 0000ffff
3 0000300c 00000003 12358764
3 00003010 00000004 0000ffff
3 00003014 00000000 12358764
3 00003018 00000005 0000ffff
3 0000301c 00000006 ffff0001
3 00003020 00000007 00000010
4 00000014 12358764 00000000
4 00000008 ffff0001 00000000
3 0000302c 00000008 12358764
3 00003030 00000009 246b0ec8
3 00003034 0000000a ffff0001
4 00000010 ffff0001 00000000
3 0000303c 0000000b cafef00d
3 00003040 0000000c ffff0001
3 00003048 0000000d 00000001
3 00003050 0000000e 246b0ec9
3 00003058 0000000f 00000002
3 0000305c 00000010 00000003
3 00003060 0000001f 00003068
3 00003064 00000011 00000005
3 00003080 00000013 00003068
3 00003088 00000014 0000306d
3 00003068 00000012 00000004
0 00000000 00000000 00000000

// File: dv/tbMipsCpu.sv
`timescale 1ns/1ps

module tbMipsCpu;

	localparam int imemWords   = 256;
	localparam int dmemWords   = 256;
	localparam int fileWords   = 512;
	localparam int waitLimit   = 40;	// Cycles allowed between trace events
	localparam int quietCycles = 30;

	localparam logic [31:0] imemBase = 32'h0000_3000;	// First fetch address after reset

	// Record kinds in the tests file
	localparam logic [31:0] recEnd   = 32'h0;
	localparam logic [31:0] recInstr = 32'h1;
	localparam logic [31:0] recData  = 32'h2;
	localparam logic [31:0] recWrite = 32'h3;
	localparam logic [31:0] recStore = 32'h4;

	typedef struct packed {
		logic [31:0] kind;
		logic [31:0] a;	// PC or byte address
		logic [31:0] b;	// Word, register index or store value
		logic [31:0] c;	// Register value
	} testRec_t;

	logic               clk;
	logic               rstN;
	logic [31:0]        instRdata;
	logic [31:0]        dataRdata;
	logic [31:0]        instAddr;
	logic [31:0]        dataAddr;
	logic [31:0]        dataWdata;
	logic [3:0]         dataByteen;
	mipsPkg::grfWrite_t grfWrite;

	logic [31:0] imem [0:imemWords-1];
	logic [31:0] dmem [0:dmemWords-1];
	logic [31:0] testWords [0:fileWords-1];
	logic [31:0] instOffset;
	testRec_t    expQ [$];	// Writes and stores in program order
	int          errors;
	int          checks;

	mipsCpu DUT (
		.clk, .rstN,
		.instRdata, .dataRdata,
		.instAddr, .dataAddr, .dataWdata, .dataByteen,
		.grfWrite
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////
	// Memory models
	////////////////////
	always_comb begin
		instOffset = instAddr - imemBase;
		if (instOffset < imemWords * 4)
			instRdata = imem[instOffset[9:2]];
		else
			instRdata = 32'h0000_0000;	// nop outside the image
	end

	always_comb begin
		if (dataAddr < dmemWords * 4)
			dataRdata = dmem[dataAddr[9:2]];
		else
			dataRdata = 32'hdead_beef;
	end

	always @(posedge clk) begin
		if (dataByteen == 4'b1111 && dataAddr < dmemWords * 4)
			dmem[dataAddr[9:2]] <= dataWdata;
	end

	task automatic loadTests();
		testRec_t    rec;
		logic [31:0] offset;
		int          pos;
		bit          done;
		for (int i = 0; i < imemWords; i++)
			imem[i] = 32'h0000_0000;
		for (int i = 0; i < dmemWords; i++)
			dmem[i] <= 32'hd000_0000 | (i << 2);	// Tagged with its own byte address
		$readmemh("dv/cpuTests.txt", testWords);
		pos  = 0;
		done = 1'b0;
		while (!done && pos + 4 <= fileWords) begin
			rec = {testWords[pos], testWords[pos + 1], testWords[pos + 2], testWords[pos + 3]};
			pos += 4;
			case (rec.kind)
				recEnd: done = 1'b1;
				recInstr: begin
					offset = rec.a - imemBase;
					imem[offset[9:2]] = rec.b;
				end
				recData: dmem[rec.a[9:2]] <= rec.b;
				recWrite, recStore: expQ.push_back(rec);
				default: begin
					errors++;
					$display("Tests file has an unreadable record at word %0d", pos - 4);
					done = 1'b1;
				end
			endcase
		end
	endtask

	////////////////////
	// Compare tasks
	////////////////////
	task automatic checkWrite(input mipsPkg::grfWrite_t expected, input mipsPkg::grfWrite_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t grfWrite (we/addr/data/pc) expected %0b/%0d/%h/%h actual %0b/%0d/%h/%h",
				$time, expected.we, expected.addr, expected.data, expected.pc,
				actual.we, actual.addr, actual.data, actual.pc);
		end
	endtask

	task automatic checkStore(
		input logic [31:0] expAddr,
		input logic [31:0] expData,
		input logic [31:0] actAddr,
		input logic [31:0] actData,
		input logic [3:0]  actByteen
	);
		checks++;
		if (actAddr !== expAddr) begin
			errors++;
			$display("FAIL %0t dataAddr expected %h actual %h", $time, expAddr, actAddr);
		end
		if (actData !== expData) begin
			errors++;
			$display("FAIL %0t dataWdata expected %h actual %h", $time, expData, actData);
		end
		if (actByteen !== 4'b1111) begin	// Whole-word stores only
			errors++;
			$display("FAIL %0t dataByteen expected 1111 actual %b", $time, actByteen);
		end
	endtask

	task automatic checkFetch(input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL %0t instAddr expected %h actual %h", $time, expected, actual);
		end
	endtask

	// Matches the port activity of this cycle against the next expected event
	task automatic takeWrite();
		testRec_t           rec;
		mipsPkg::grfWrite_t expected;
		if (expQ.size() == 0) begin
			errors++;
			$display("Unexpected register write to $%0d after the last expected event",
				grfWrite.addr);
		end else begin
			rec = expQ.pop_front();
			if (rec.kind != recWrite) begin
				errors++;
				$display("Register write from pc %h came where a store to %h was expected",
					grfWrite.pc, rec.a);
			end else begin
				expected.we   = 1'b1;
				expected.addr = rec.b[4:0];
				expected.data = rec.c;
				expected.pc   = rec.a;
				checkWrite(expected, grfWrite);
			end
		end
	endtask

	task automatic takeStore();
		testRec_t rec;
		if (expQ.size() == 0) begin
			errors++;
			$display("Unexpected store to %h after the last expected event", dataAddr);
		end else begin
			rec = expQ.pop_front();
			if (rec.kind != recStore) begin
				errors++;
				$display("Store to %h came where a register write from pc %h was expected",
					dataAddr, rec.a);
			end else begin
				checkStore(rec.a, rec.b, dataAddr, dataWdata, dataByteen);
			end
		end
	endtask

	task automatic waitTraceEvent(output bit timedOut);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!grfWrite.we && dataByteen == 4'b0000 && cycles < waitLimit);
		timedOut = !grfWrite.we && dataByteen == 4'b0000;
	endtask

	initial begin
		bit hung;
		errors = 0;
		checks = 0;
		hung   = 1'b0;
		rstN   = 1'b0;
		loadTests();
		if (expQ.size() == 0) begin
			errors++;
			$display("Tests file holds no expected trace events");
		end
		repeat (8) @(negedge clk);
		checkFetch(imemBase, instAddr);
		if (grfWrite.we || dataByteen != 4'b0000) begin
			errors++;
			$display("Trace or store port active during reset");
		end
		rstN = 1'b1;
		while (expQ.size() > 0 && !hung) begin
			waitTraceEvent(hung);
			if (hung) begin
				errors++;
				$display("Timeout at %0t: core stopped producing writes, %0d events left",
					$time, expQ.size());
			end else begin
				// Write-back holds the older instruction
				if (grfWrite.we)
					takeWrite();
				if (dataByteen != 4'b0000)
					takeStore();
			end
		end
		if (!hung) begin
			repeat (quietCycles) begin	// Program ends in a self loop
				@(negedge clk);
				if (grfWrite.we || dataByteen != 4'b0000) begin
					errors++;
					$display("Trace event at %0t after the last expected one", $time);
				end
			end
		end
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: list.f
verilog/mipsPkg.sv
verilog/fetchUnit.sv
verilog/regFile.sv
verilog/decodeUnit.sv
verilog/execUnit.sv
verilog/memWbUnit.sv
verilog/mipsCpu.sv
dv/tbMipsCpu.sv

// File: verilog/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit (
	input  logic                clk,
	input  logic                rstN,
	input  mipsPkg::fdReg_t     fd,
	input  logic [31:0]         rsVal,
	input  logic [31:0]         rtVal,
	input  mipsPkg::fwdSrc_t    memFwd,
	input  mipsPkg::grfWrite_t  wbFwd,
	input  logic [4:0]          exLoadDest,
	input  logic                exIsLoad,
	output logic [4:0]          rsIdx,
	output logic [4:0]          rtIdx,
	output logic                stall,
	output logic                redirect,
	output logic [31:0]         target,
	output mipsPkg::deReg_t     de
);

	mipsPkg::instrOp_e op;
	mipsPkg::deReg_t   deNext;
	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  rdIdx;
	logic [15:0] imm16;
	logic [31:0] pcPlus4;
	logic [31:0] rsFwd;
	logic [31:0] rtFwd;
	logic        useRs;
	logic        useRt;
	logic        taken;
	logic        needEarly;	// beq and jr consume operands in decode
	logic        loadHazard;
	logic        earlyHazard;
	logic [4:0]  memLoadIdx;	// Load now in the memory stage, 0 if none

	function automatic logic srcMatch(
		input logic [4:0] dest,
		input logic [4:0] rs,
		input logic [4:0] rt,
		input logic       rsUsed,
		input logic       rtUsed
	);
		return dest != 5'd0 && ((rsUsed && rs == dest) || (rtUsed && rt == dest));
	endfunction

	assign opcode = fd.instr[31:26];
	assign rsIdx  = fd.instr[25:21];
	assign rtIdx  = fd.instr[20:16];
	assign rdIdx  = fd.instr[15:11];
	assign funct  = fd.instr[5:0];
	assign imm16  = fd.instr[15:0];

	always_comb begin
		op = mipsPkg::opNop;	// Unknown words fall through as nop
		case (opcode)
			mipsPkg::opcSpecial: begin
				case (funct)
					mipsPkg::fnAddu: op = mipsPkg::opAddu;
					mipsPkg::fnSubu: op = mipsPkg::opSubu;
					mipsPkg::fnJr:   op = mipsPkg::opJr;
					default:         op = mipsPkg::opNop;
				endcase
			end
			mipsPkg::opcOri: op = mipsPkg::opOri;
			mipsPkg::opcLui: op = mipsPkg::opLui;
			mipsPkg::opcLw:  op = mipsPkg::opLw;
			mipsPkg::opcSw:  op = mipsPkg::opSw;
			mipsPkg::opcBeq: op = mipsPkg::opBeq;
			mipsPkg::opcJal: op = mipsPkg::opJal;
			default:         op = mipsPkg::opNop;
		endcase
	end

	assign rsFwd = mipsPkg::forward(rsIdx, rsVal, memFwd, wbFwd);
	assign rtFwd = mipsPkg::forward(rtIdx, rtVal, memFwd, wbFwd);

	////////////////////
	// Control fields
	////////////////////
	always_comb begin
		deNext       = '0;
		deNext.pc    = fd.pc;
		deNext.op    = op;
		deNext.rsVal = rsFwd;
		deNext.rtVal = rtFwd;
		deNext.rsIdx = rsIdx;
		deNext.rtIdx = rtIdx;
		useRs = 1'b0;
		useRt = 1'b0;
		case (op)
			mipsPkg::opAddu, mipsPkg::opSubu: begin
				deNext.aluOp    = (op == mipsPkg::opSubu) ? mipsPkg::aluSub : mipsPkg::aluAdd;
				deNext.destIdx  = rdIdx;
				deNext.regWrite = 1'b1;
				useRs = 1'b1;
				useRt = 1'b1;
			end
			mipsPkg::opOri: begin
				deNext.aluOp    = mipsPkg::aluOr;
				deNext.imm      = {16'h0000, imm16};	// Zero-extended
				deNext.useImm   = 1'b1;
				deNext.destIdx  = rtIdx;
				deNext.regWrite = 1'b1;
				useRs = 1'b1;
			end
			mipsPkg::opLui: begin
				deNext.aluOp    = mipsPkg::aluLui;
				deNext.imm      = {imm16, 16'h0000};
				deNext.useImm   = 1'b1;
				deNext.destIdx  = rtIdx;
				deNext.regWrite = 1'b1;
			end
			mipsPkg::opLw: begin
				deNext.imm      = {{16{imm16[15]}}, imm16};
				deNext.useImm   = 1'b1;
				deNext.destIdx  = rtIdx;
				deNext.regWrite = 1'b1;
				deNext.wbSel    = mipsPkg::wbMem;
				useRs = 1'b1;
			end
			mipsPkg::opSw: begin
				deNext.imm      = {{16{imm16[15]}}, imm16};
				deNext.useImm   = 1'b1;
				deNext.memWrite = 1'b1;
				useRs = 1'b1;
				useRt = 1'b1;	// Store data
			end
			mipsPkg::opBeq: begin
				useRs = 1'b1;
				useRt = 1'b1;
			end
			mipsPkg::opJal: begin
				deNext.destIdx  = mipsPkg::linkReg;
				deNext.regWrite = 1'b1;
				deNext.wbSel    = mipsPkg::wbLink;
			end
			mipsPkg::opJr: useRs = 1'b1;
			default: ;
		endcase
	end

	////////////////////
	// Branch and jump
	////////////////////
	assign pcPlus4 = fd.pc + 32'd4;

	always_comb begin
		taken  = 1'b0;
		target = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
		case (op)
			mipsPkg::opBeq: taken = (rsFwd == rtFwd);
			mipsPkg::opJal: begin
				taken  = 1'b1;
				target = {pcPlus4[31:28], fd.instr[25:0], 2'b00};
			end
			mipsPkg::opJr: begin
				taken  = 1'b1;
				target = rsFwd;
			end
			default: ;
		endcase
	end

	// Hazards
	assign needEarly   = (op == mipsPkg::opBeq) || (op == mipsPkg::opJr);
	assign loadHazard  = exIsLoad && srcMatch(exLoadDest, rsIdx, rtIdx, useRs, useRt);
	// Compare needs the value now; execute results and memory-stage loads are too late
	assign earlyHazard = needEarly &&
		((de.regWrite && srcMatch(de.destIdx, rsIdx, rtIdx, useRs, useRt)) ||
		srcMatch(memLoadIdx, rsIdx, rtIdx, useRs, useRt));
	assign stall       = loadHazard || earlyHazard;
	assign redirect    = taken && !stall;	// Resolve only with valid operands

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			de         <= '0;
			memLoadIdx <= '0;
		end else begin
			if (stall)
				de <= '0;	// Bubble
			else
				de <= deNext;
			memLoadIdx <= exIsLoad ? exLoadDest : 5'd0;
		end
	end

endmodule

// File: verilog/execUnit.sv
`timescale 1ns/1ps

module execUnit (
	input  logic                clk,
	input  logic                rstN,
	input  mipsPkg::deReg_t     de,
	input  mipsPkg::grfWrite_t  wbFwd,
	output mipsPkg::emReg_t     em,
	output mipsPkg::fwdSrc_t    memFwd,
	output logic [4:0]          exLoadDest,
	output logic                exIsLoad
);

	mipsPkg::emReg_t emNext;
	logic [31:0] opA;
	logic [31:0] rtFwd;
	logic [31:0] opB;
	logic [31:0] aluOut;

	// Producers that were still in execute when these operands were read
	assign opA   = mipsPkg::forward(de.rsIdx, de.rsVal, memFwd, wbFwd);
	assign rtFwd = mipsPkg::forward(de.rtIdx, de.rtVal, memFwd, wbFwd);
	assign opB   = de.useImm ? de.imm : rtFwd;

	////////////////////
	// ALU
	////////////////////
	always_comb begin
		case (de.aluOp)
			mipsPkg::aluAdd: aluOut = opA + opB;
			mipsPkg::aluSub: aluOut = opA - opB;
			mipsPkg::aluOr:  aluOut = opA | opB;
			mipsPkg::aluLui: aluOut = opB;	// Imm arrives pre-shifted
			default:         aluOut = opA + opB;
		endcase
	end

	always_comb begin
		emNext          = '0;
		emNext.pc       = de.pc;
		// jal carries its link so the forward path sees it
		emNext.aluRes   = (de.wbSel == mipsPkg::wbLink) ? de.pc + 32'd8 : aluOut;
		emNext.storeVal = rtFwd;
		emNext.rtIdx    = de.rtIdx;
		emNext.destIdx  = de.destIdx;
		emNext.regWrite = de.regWrite;
		emNext.memWrite = de.memWrite;
		emNext.wbSel    = de.wbSel;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			em <= '0;
		else
			em <= emNext;
	end

	// Load data does not exist until the memory stage returns it
	assign memFwd.valid = em.regWrite && (em.wbSel != mipsPkg::wbMem);
	assign memFwd.idx   = em.destIdx;
	assign memFwd.data  = em.aluRes;

	// Load-use detection in decode
	assign exLoadDest = de.destIdx;
	assign exIsLoad   = (de.op == mipsPkg::opLw);

endmodule

// File: verilog/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
	input  logic             clk,
	input  logic             rstN,
	input  logic             stall,
	input  logic             redirect,
	input  logic [31:0]      target,
	input  logic [31:0]      instRdata,
	output logic [31:0]      instAddr,
	output mipsPkg::fdReg_t  fd
);

	logic [31:0] pc;
	logic [31:0] pcNext;

	// Next PC
	// redirect arrives while the delay slot is being fetched,
	// so target becomes the PC right after the slot
	always_comb begin
		if (stall)
			pcNext = pc;
		else if (redirect)
			pcNext = target;
		else
			pcNext = pc + 32'd4;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= mipsPkg::resetPc;
		else
			pc <= pcNext;
	end

	assign instAddr = pc;	// Instruction memory answers in the same cycle

	////////////////////
	// F/D register
	////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fd <= '0;	// All-zero word is a nop
		end else if (!stall) begin
			fd.pc    <= pc;
			fd.instr <= instRdata;
		end
	end

endmodule

// File: verilog/memWbUnit.sv
`timescale 1ns/1ps

module memWbUnit (
	input  logic                clk,
	input  logic                rstN,
	input  mipsPkg::emReg_t     em,
	input  logic [31:0]         dataRdata,
	output logic [31:0]         dataAddr,
	output logic [31:0]         dataWdata,
	output logic [3:0]          dataByteen,
	output mipsPkg::grfWrite_t  grfWrite
);

	mipsPkg::mwReg_t mw;
	logic [31:0] storeVal;

	////////////////////
	// Memory stage
	////////////////////
	// Store data may still be in flight from the write-back stage
	always_comb begin
		if (grfWrite.we && grfWrite.addr != 5'd0 && grfWrite.addr == em.rtIdx)
			storeVal = grfWrite.data;
		else
			storeVal = em.storeVal;
	end

	assign dataAddr   = em.aluRes;
	assign dataWdata  = storeVal;
	assign dataByteen = em.memWrite ? 4'b1111 : 4'b0000;	// Whole words only

	// M/W register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mw <= '0;
		end else begin
			mw.pc       <= em.pc;
			mw.aluRes   <= em.aluRes;
			mw.memData  <= dataRdata;
			mw.destIdx  <= em.destIdx;
			mw.regWrite <= em.regWrite;
			mw.wbSel    <= em.wbSel;
		end
	end

	////////////////////
	// Write-back
	////////////////////
	always_comb begin
		grfWrite.we   = mw.regWrite;
		grfWrite.addr = mw.destIdx;
		grfWrite.pc   = mw.pc;
		case (mw.wbSel)
			mipsPkg::wbMem:  grfWrite.data = mw.memData;
			mipsPkg::wbLink: grfWrite.data = mw.pc + 32'd8;
			default:         grfWrite.data = mw.aluRes;
		endcase
	end

endmodule

// File: verilog/mipsCpu.sv
`timescale 1ns/1ps

module mipsCpu (
	input  logic                clk,
	input  logic                rstN,
	input  logic [31:0]         instRdata,
	input  logic [31:0]         dataRdata,
	output logic [31:0]         instAddr,
	output logic [31:0]         dataAddr,
	output logic [31:0]         dataWdata,
	output logic [3:0]          dataByteen,
	output mipsPkg::grfWrite_t  grfWrite
);

	mipsPkg::fdReg_t  fd;
	mipsPkg::deReg_t  de;
	mipsPkg::emReg_t  em;
	mipsPkg::fwdSrc_t memFwd;
	logic        stall;
	logic        redirect;
	logic [31:0] target;
	logic [4:0]  rsIdx;
	logic [4:0]  rtIdx;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [4:0]  exLoadDest;
	logic        exIsLoad;

	fetchUnit fetch (
		.clk, .rstN,
		.stall, .redirect, .target,
		.instRdata, .instAddr,
		.fd
	);

	regFile grf (
		.clk, .rstN,
		.rsIdx, .rtIdx,
		.wr (grfWrite),	// Write-back port
		.rsVal, .rtVal
	);

	decodeUnit decode (
		.clk, .rstN,
		.fd, .rsVal, .rtVal,
		.memFwd,
		.wbFwd (grfWrite),
		.exLoadDest, .exIsLoad,
		.rsIdx, .rtIdx,
		.stall, .redirect, .target,
		.de
	);

	execUnit exec (
		.clk, .rstN,
		.de,
		.wbFwd (grfWrite),
		.em, .memFwd,
		.exLoadDest, .exIsLoad
	);

	memWbUnit memWb (
		.clk, .rstN,
		.em, .dataRdata,
		.dataAddr, .dataWdata, .dataByteen,
		.grfWrite
	);

endmodule

// File: verilog/mipsPkg.sv
package mipsPkg;

	////////////////////
	// Constants
	////////////////////
	localparam logic [31:0] resetPc = 32'h0000_3000;	// First fetch address
	localparam logic [4:0]  linkReg = 5'd31;	// Written by jal

	// Primary opcode field values
	localparam logic [5:0] opcSpecial = 6'h00;
	localparam logic [5:0] opcJal     = 6'h03;
	localparam logic [5:0] opcBeq     = 6'h04;
	localparam logic [5:0] opcOri     = 6'h0d;
	localparam logic [5:0] opcLui     = 6'h0f;
	localparam logic [5:0] opcLw      = 6'h23;
	localparam logic [5:0] opcSw      = 6'h2b;

	// Funct field values for SPECIAL
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;

	////////////////////
	// Encodings
	////////////////////
	// Zero values are what a cleared pipeline register holds, i.e. a nop
	typedef enum logic [3:0] {
		opNop, opAddu, opSubu, opOri, opLui, opLw, opSw, opBeq, opJal, opJr
	} instrOp_e;

	typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOp_e;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel_e;

	////////////////////
	// Pipeline records
	////////////////////
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fdReg_t;

	typedef struct packed {
		logic [31:0] pc;
		instrOp_e    op;
		aluOp_e      aluOp;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;	// Already extended or shifted
		logic        useImm;
		logic [4:0]  rsIdx;
		logic [4:0]  rtIdx;
		logic [4:0]  destIdx;
		logic        regWrite;
		logic        memWrite;
		wbSel_e      wbSel;
	} deReg_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluRes;	// Link value for jal
		logic [31:0] storeVal;
		logic [4:0]  rtIdx;
		logic [4:0]  destIdx;
		logic        regWrite;
		logic        memWrite;
		wbSel_e      wbSel;
	} emReg_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] aluRes;
		logic [31:0] memData;
		logic [4:0]  destIdx;
		logic        regWrite;
		wbSel_e      wbSel;
	} mwReg_t;

	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
		logic [31:0] pc;
	} grfWrite_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  idx;
		logic [31:0] data;
	} fwdSrc_t;

	// Newest producer wins: memory stage first, then write-back
	function automatic logic [31:0] forward(
		input logic [4:0]  idx,
		input logic [31:0] regVal,
		input fwdSrc_t     memSrc,
		input grfWrite_t   wbSrc
	);
		if (idx == 5'd0)
			return regVal;
		if (memSrc.valid && memSrc.idx == idx)
			return memSrc.data;
		if (wbSrc.we && wbSrc.addr == idx)
			return wbSrc.data;
		return regVal;
	endfunction

endpackage

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                clk,
	input  logic                rstN,
	input  logic [4:0]          rsIdx,
	input  logic [4:0]          rtIdx,
	input  mipsPkg::grfWrite_t  wr,
	output logic [31:0]         rsVal,
	output logic [31:0]         rtVal
);

	logic [31:0] regs [1:31];	// $0 has no storage

	// Zero for $0, and the value being written this cycle wins
	function automatic logic [31:0] readPort(
		input logic [4:0]         idx,
		input logic [31:0]        stored,
		input mipsPkg::grfWrite_t w
	);
		if (idx == 5'd0)
			return 32'd0;
		if (w.we && w.addr == idx)
			return w.data;
		return stored;
	endfunction

	assign rsVal = readPort(rsIdx, regs[rsIdx], wr);
	assign rtVal = readPort(rtIdx, regs[rtIdx], wr);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr.we && wr.addr != 5'd0) begin
			regs[wr.addr] <= wr.data;
		end
	end

endmodule
